// File: include/insert_params.svh
// widths are fixed at compile time; INS_CNT_W must be at least INS_LEN_W, and the data width is whole bytes
`ifndef INSERT_PARAMS_SVH
`define INSERT_PARAMS_SVH

// stream payload
`define INS_DATA_W 32
`define INS_KEEP_W (`INS_DATA_W/8)

// beat-in-packet counter, also the seed width
`define INS_CNT_W 16

// number of extra copies
`define INS_LEN_W 8

// apb byte address
`define INS_APB_AW 4

// register map
`define INS_CFG_OFS    4'h0
`define INS_COPIES_OFS 4'h4

`endif

// File: rtl/insert_pkg.sv
// config layout is one 32-bit apb word; the top 8 bits are reserved and read back as written
`default_nettype none

`include "insert_params.svh"

package insert_pkg;

    // field view of the CFG register, msb first
    typedef struct packed {
        logic [7:0]             rsvd;
        logic [`INS_CNT_W-1:0]  seed;
        logic [`INS_LEN_W-1:0]  len;
    } insert_cfg_t;

    // apb writes land on raw, the datapath reads fields
    typedef union packed {
        logic [31:0]  raw;
        insert_cfg_t  f;
    } insert_cfg_u;

endpackage

`default_nettype wire

// File: rtl/insert_apb_regs.sv
// zero-wait apb slave with no error responses; CFG should only be written while the stream is idle
`default_nettype none
`timescale 1ns/1ns

`include "insert_params.svh"

module insert_apb_regs (
    input  wire                    clock,
    input  wire                    rst_n,
    input  wire [`INS_APB_AW-1:0]  paddr,
    input  wire                    psel,
    input  wire                    penable,
    input  wire                    pwrite,
    input  wire [31:0]             pwdata,
    input  wire                    copy_pulse,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output insert_pkg::insert_cfg_t cfg
);

    import insert_pkg::*;

    insert_cfg_u  cfg_q;
    logic [31:0]  copies_q;
    logic         wr_en;

    // access phase write, single cycle
    assign wr_en = psel && penable && pwrite;

    // configuration word, raw view on write
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q.raw <= 32'd0;
        end else if (wr_en && (paddr == `INS_CFG_OFS)) begin
            cfg_q.raw <= pwdata;
        end
    end

    // inserted copy counter
    // any write clears, otherwise add one per copy
    // wraps silently at 32 bits
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            copies_q <= 32'd0;
        end else if (wr_en && (paddr == `INS_COPIES_OFS)) begin
            copies_q <= 32'd0;
        end else if (copy_pulse) begin
            copies_q <= copies_q + 32'd1;
        end
    end

    // read mux, unmapped offsets give zero
    always_comb begin
        case (paddr)
            `INS_CFG_OFS:    prdata = cfg_q.raw;
            `INS_COPIES_OFS: prdata = copies_q;
            default:         prdata = 32'd0;
        endcase
    end

    // never stalls, never errors
    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    // field view to the inserter
    assign cfg = cfg_q.f;

endmodule

`default_nettype wire

// File: rtl/axis_insert_copy.sv
// beat_cnt must come from a pipe that counts every accepted beat, copies included; cfg is static during a packet
`default_nettype none
`timescale 1ns/1ns

`include "insert_params.svh"

module axis_insert_copy (
    input  wire                     clock,
    input  wire                     rst_n,
    input  wire insert_pkg::insert_cfg_t cfg,
    input  wire [`INS_DATA_W-1:0]   s_tdata,
    input  wire [`INS_KEEP_W-1:0]   s_tkeep,
    input  wire                     s_tlast,
    input  wire                     s_tvalid,
    input  wire                     v_tready,
    input  wire [`INS_CNT_W-1:0]    beat_cnt,
    output logic                    s_tready,
    output logic [`INS_DATA_W-1:0]  v_tdata,
    output logic [`INS_KEEP_W-1:0]  v_tkeep,
    output logic                    v_tlast,
    output logic                    v_tvalid,
    output logic                    copy_pulse
);

    logic                   hold_q;
    logic                   arm_q;
    logic                   holding;
    logic                   hold_next;
    logic                   v_xfer;
    logic                   seed_zero;
    logic                   len_nz;
    logic                   in_window;
    logic [`INS_CNT_W-1:0]  win_lo;
    logic [`INS_CNT_W:0]    win_end;
    logic [`INS_LEN_W-1:0]  len_m1;

    assign seed_zero = (cfg.seed == '0);
    assign len_nz    = (cfg.len != '0);

    // seed zero holds the first beat straight from the arm
    assign holding = len_nz && (hold_q || (seed_zero && arm_q));

    // data path is pass-through, only ready and last are gated
    assign v_tdata  = s_tdata;
    assign v_tkeep  = s_tkeep;
    assign v_tvalid = s_tvalid;
    assign v_tlast  = s_tlast && !holding;
    assign s_tready = v_tready && !holding;

    assign v_xfer = v_tvalid && v_tready;

    // one pulse per re-presented beat
    assign copy_pulse = v_xfer && holding;

    // window of beat_cnt values that keep the hold, [S-1, S+L-1)
    // one bit wider on the top end so a large seed plus len cannot wrap
    assign win_lo  = cfg.seed - 1'b1;
    assign win_end = {1'b0, cfg.seed}
                   + {{(`INS_CNT_W + 1 - `INS_LEN_W){1'b0}}, cfg.len} - 1'b1;
    assign in_window = (beat_cnt >= win_lo) && ({1'b0, beat_cnt} < win_end);

    assign len_m1 = cfg.len - 1'b1;

    always_comb begin
        if (!len_nz) begin
            hold_next = 1'b0;
        end else if (seed_zero) begin
            // keep repeating beat 0 until L copies went out
            hold_next = holding
                && (beat_cnt < {{(`INS_CNT_W - `INS_LEN_W){1'b0}}, len_m1});
        end else begin
            // entry needs beat S-1 not to be last
            // once holding, the held beat's own tlast does not matter
            hold_next = in_window && (holding || !s_tlast);
        end
    end

    // both flags move only on a pipe-side transfer
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            hold_q <= 1'b0;
            arm_q  <= 1'b1;
        end else if (v_xfer) begin
            hold_q <= hold_next;
            // re-arm after the input's last beat leaves
            arm_q  <= v_tlast;
        end
    end

endmodule

`default_nettype wire

// File: rtl/axis_beat_pipe.sv
// ready is registered, so v_tready sits low for one cycle after reset; beat_cnt wraps on packets over 64k beats
`default_nettype none
`timescale 1ns/1ns

`include "insert_params.svh"

module axis_beat_pipe (
    input  wire                     clock,
    input  wire                     rst_n,
    input  wire [`INS_DATA_W-1:0]   v_tdata,
    input  wire [`INS_KEEP_W-1:0]   v_tkeep,
    input  wire                     v_tlast,
    input  wire                     v_tvalid,
    input  wire                     m_tready,
    output logic                    v_tready,
    output logic [`INS_CNT_W-1:0]   beat_cnt,
    output logic [`INS_DATA_W-1:0]  m_tdata,
    output logic [`INS_KEEP_W-1:0]  m_tkeep,
    output logic                    m_tlast,
    output logic                    m_tvalid
);

    logic                    skid_valid;
    logic                    skid_next;
    logic                    main_load;
    logic                    in_xfer;
    logic [`INS_DATA_W-1:0]  skid_tdata;
    logic [`INS_KEEP_W-1:0]  skid_tkeep;
    logic                    skid_tlast;

    assign in_xfer = v_tvalid && v_tready;

    // output register free or draining this cycle
    assign main_load = !m_tvalid || m_tready;

    // skid fills only when main is stuck, drains into main first
    assign skid_next = main_load ? 1'b0 : (skid_valid || in_xfer);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            m_tvalid   <= 1'b0;
            skid_valid <= 1'b0;
            v_tready   <= 1'b0;
        end else begin
            if (main_load) begin
                m_tvalid <= skid_valid || in_xfer;
            end
            skid_valid <= skid_next;
            // cut ready path, accept only with a free skid slot
            v_tready   <= !skid_next;
        end
    end

    // payload, no reset
    always_ff @(posedge clock) begin
        if (main_load) begin
            if (skid_valid) begin
                m_tdata <= skid_tdata;
                m_tkeep <= skid_tkeep;
                m_tlast <= skid_tlast;
            end else if (in_xfer) begin
                m_tdata <= v_tdata;
                m_tkeep <= v_tkeep;
                m_tlast <= v_tlast;
            end
        end else if (in_xfer) begin
            skid_tdata <= v_tdata;
            skid_tkeep <= v_tkeep;
            skid_tlast <= v_tlast;
        end
    end

    // beats accepted in the current packet
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (in_xfer) begin
            beat_cnt <= v_tlast ? '0 : beat_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/insert_top.sv
// single clock and reset for apb and stream; tuser is not carried and pslverr is tied low
`default_nettype none
`timescale 1ns/1ns

`include "insert_params.svh"

module insert_top (
    input  wire                     clock,
    input  wire                     rst_n,
    input  wire [`INS_APB_AW-1:0]   paddr,
    input  wire                     psel,
    input  wire                     penable,
    input  wire                     pwrite,
    input  wire [31:0]              pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  wire [`INS_DATA_W-1:0]   s_tdata,
    input  wire [`INS_KEEP_W-1:0]   s_tkeep,
    input  wire                     s_tlast,
    input  wire                     s_tvalid,
    output logic                    s_tready,
    output logic [`INS_DATA_W-1:0]  m_tdata,
    output logic [`INS_KEEP_W-1:0]  m_tkeep,
    output logic                    m_tlast,
    output logic                    m_tvalid,
    input  wire                     m_tready
);

    import insert_pkg::*;

    insert_cfg_t             cfg;
    logic                    copy_pulse;
    logic [`INS_DATA_W-1:0]  v_tdata;
    logic [`INS_KEEP_W-1:0]  v_tkeep;
    logic                    v_tlast;
    logic                    v_tvalid;
    logic                    v_tready;
    logic [`INS_CNT_W-1:0]   beat_cnt;

    // control registers
    insert_apb_regs u_regs (
        .clock      (clock),
        .rst_n      (rst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .copy_pulse (copy_pulse),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .cfg        (cfg)
    );

    // copy inserter, combinational on data
    axis_insert_copy u_insert (
        .clock      (clock),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .s_tdata    (s_tdata),
        .s_tkeep    (s_tkeep),
        .s_tlast    (s_tlast),
        .s_tvalid   (s_tvalid),
        .v_tready   (v_tready),
        .beat_cnt   (beat_cnt),
        .s_tready   (s_tready),
        .v_tdata    (v_tdata),
        .v_tkeep    (v_tkeep),
        .v_tlast    (v_tlast),
        .v_tvalid   (v_tvalid),
        .copy_pulse (copy_pulse)
    );

    // output slice, beat count goes back to the inserter
    axis_beat_pipe u_pipe (
        .clock    (clock),
        .rst_n    (rst_n),
        .v_tdata  (v_tdata),
        .v_tkeep  (v_tkeep),
        .v_tlast  (v_tlast),
        .v_tvalid (v_tvalid),
        .m_tready (m_tready),
        .v_tready (v_tready),
        .beat_cnt (beat_cnt),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tlast  (m_tlast),
        .m_tvalid (m_tvalid)
    );

endmodule

`default_nettype wire

// File: tb/insert_tb.sv
// directed tests only, stops at the first mismatch; each wait gives up after 200 clock cycles
`default_nettype none
`timescale 1ns/1ns

`include "insert_params.svh"

module insert_tb;

    import insert_pkg::*;

    logic                    clock;
    logic                    rst_n;
    logic [`INS_APB_AW-1:0]  paddr;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [31:0]             pwdata;
    logic [31:0]             prdata;
    logic                    pready;
    logic                    pslverr;
    logic [`INS_DATA_W-1:0]  s_tdata;
    logic [`INS_KEEP_W-1:0]  s_tkeep;
    logic                    s_tlast;
    logic                    s_tvalid;
    logic                    s_tready;
    logic [`INS_DATA_W-1:0]  m_tdata;
    logic [`INS_KEEP_W-1:0]  m_tkeep;
    logic                    m_tlast;
    logic                    m_tvalid;
    logic                    m_tready;

    // packet under test and the beats the model expects
    logic [`INS_DATA_W-1:0]  pkt_data[$];
    logic [`INS_DATA_W-1:0]  exp_data[$];
    logic [`INS_KEEP_W-1:0]  exp_keep[$];
    logic                    exp_last[$];
    logic [31:0]             exp_copies;
    int                      cur_seed;
    int                      cur_len;

    insert_top DUT (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic abort_run(input string why);
        if (why != "") begin
            $display("%s", why);
        end
        $display("Test failures found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare_beat(input logic [`INS_DATA_W-1:0] exp_d,
                                input logic [`INS_KEEP_W-1:0] exp_k, input logic exp_l);
        if (m_tdata !== exp_d) begin
            $display("[ERROR] %0t m_tdata expected %h got %h", $time, exp_d, m_tdata);
            abort_run("");
        end
        if (m_tkeep !== exp_k) begin
            $display("[ERROR] %0t m_tkeep expected %h got %h", $time, exp_k, m_tkeep);
            abort_run("");
        end
        if (m_tlast !== exp_l) begin
            $display("[ERROR] %0t m_tlast expected %b got %b", $time, exp_l, m_tlast);
            abort_run("");
        end
    endtask

    // field-wise, so a swapped field shows by name
    task automatic compare_cfg(input insert_cfg_t exp_c, input insert_cfg_t act_c);
        if (act_c.seed !== exp_c.seed) begin
            $display("[ERROR] %0t cfg.seed expected %h got %h", $time, exp_c.seed, act_c.seed);
            abort_run("");
        end
        if (act_c.len !== exp_c.len) begin
            $display("[ERROR] %0t cfg.len expected %h got %h", $time, exp_c.len, act_c.len);
            abort_run("");
        end
        if (act_c.rsvd !== exp_c.rsvd) begin
            $display("[ERROR] %0t cfg.rsvd expected %h got %h", $time, exp_c.rsvd, act_c.rsvd);
            abort_run("");
        end
    endtask

    task automatic compare_count(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp_v, act_v);
            abort_run("");
        end
    endtask

    // setup phase, then access phase until pready at a falling edge
    task automatic apb_access(input logic wr, input logic [`INS_APB_AW-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(posedge clock);
        #1;
        paddr  = addr;
        pwdata = wdata;
        pwrite = wr;
        psel   = 1'b1;
        @(posedge clock);
        #1;
        penable = 1'b1;
        waited  = 0;
        @(negedge clock);
        while (!pready) begin
            waited++;
            if (waited >= 200) begin
                abort_run("timeout waiting for pready");
            end
            @(negedge clock);
        end
        rdata = prdata;
        // no error responses in this slave
        if (pslverr !== 1'b0) begin
            $display("[ERROR] %0t pslverr expected 0 got %b", $time, pslverr);
            abort_run("");
        end
        @(posedge clock);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [`INS_APB_AW-1:0] addr, input logic [31:0] data);
        logic [31:0] unused_rd;
        apb_access(1'b1, addr, data, unused_rd);
    endtask

    task automatic apb_read(input logic [`INS_APB_AW-1:0] addr, output logic [31:0] data);
        apb_access(1'b0, addr, 32'd0, data);
    endtask

    task automatic set_cfg(input logic [`INS_CNT_W-1:0] seed, input logic [`INS_LEN_W-1:0] len);
        insert_cfg_u w;
        w.raw    = 32'd0;
        w.f.seed = seed;
        w.f.len  = len;
        apb_write(`INS_CFG_OFS, w.raw);
        cur_seed = int'(seed);
        cur_len  = int'(len);
    endtask

    // full keep, last beat drops its top byte
    function automatic logic [`INS_KEEP_W-1:0] beat_keep(input int i, input int n);
        return (i == n - 1) ? ({`INS_KEEP_W{1'b1}} >> 1) : {`INS_KEEP_W{1'b1}};
    endfunction

    // beat number seed comes out len extra times if the packet reaches it
    task automatic build_expected;
        int n;
        int reps;
        n = pkt_data.size();
        for (int i = 0; i < n; i++) begin
            reps = (cur_len > 0 && i == cur_seed) ? cur_len + 1 : 1;
            for (int r = 0; r < reps; r++) begin
                exp_data.push_back(pkt_data[i]);
                exp_keep.push_back(beat_keep(i, n));
                exp_last.push_back((i == n - 1) && (r == reps - 1));
            end
        end
        if (cur_len > 0 && n > cur_seed) begin
            exp_copies += cur_len;
        end
    endtask

    // valid stays up for the whole packet
    task automatic send_packet;
        int waited;
        for (int i = 0; i < pkt_data.size(); i++) begin
            @(posedge clock);
            #1;
            s_tdata  = pkt_data[i];
            s_tkeep  = beat_keep(i, pkt_data.size());
            s_tlast  = (i == pkt_data.size() - 1);
            s_tvalid = 1'b1;
            waited   = 0;
            @(negedge clock);
            while (!s_tready) begin
                waited++;
                if (waited >= 200) begin
                    abort_run("timeout waiting for s_tready");
                end
                @(negedge clock);
            end
        end
        @(posedge clock);
        #1;
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    // beats are taken at the falling edge, they move on the next rising edge
    task automatic collect_packet(input bit bp);
        int waited;
        bit done;
        waited = 0;
        done   = 1'b0;
        while (!done) begin
            @(posedge clock);
            #1;
            m_tready = bp ? (($urandom & 1) == 1) : 1'b1;
            @(negedge clock);
            if (m_tvalid && m_tready) begin
                if (exp_data.size() == 0) begin
                    abort_run("output beat arrived with no beat left in the model");
                end
                compare_beat(exp_data.pop_front(), exp_keep.pop_front(), exp_last.pop_front());
                done   = m_tlast;
                waited = 0;
            end else begin
                waited++;
                if (waited >= 200) begin
                    abort_run("timeout waiting for an output beat");
                end
            end
        end
    endtask

    task automatic run_packet(input int n, input bit bp);
        pkt_data.delete();
        for (int i = 0; i < n; i++) begin
            pkt_data.push_back($urandom);
        end
        build_expected();
        fork
            send_packet();
            collect_packet(bp);
        join
        if (exp_data.size() != 0) begin
            abort_run("expected beats never reached the output");
        end
    endtask

    // COPIES against the model, then any write clears it
    task automatic check_copies;
        logic [31:0] rd;
        apb_read(`INS_COPIES_OFS, rd);
        compare_count("copies", exp_copies, rd);
        apb_write(`INS_COPIES_OFS, 32'h1234_5678);
        apb_read(`INS_COPIES_OFS, rd);
        compare_count("copies after clear", 32'd0, rd);
        exp_copies = 32'd0;
    endtask

    task automatic test_registers;
        insert_cfg_u  wr;
        insert_cfg_u  rd;
        logic [31:0]  word;
        // reset value and plain pass-through
        apb_read(`INS_CFG_OFS, word);
        rd.raw = word;
        compare_cfg('0, rd.f);
        run_packet(5, 1'b0);
        // reserved bits read back as written
        wr.raw = {8'ha5, 16'h0123, 8'h45};
        apb_write(`INS_CFG_OFS, wr.raw);
        apb_read(`INS_CFG_OFS, word);
        rd.raw = word;
        compare_cfg(wr.f, rd.f);
        apb_read(4'h8, word);
        compare_count("prdata at 0x8", 32'd0, word);
        apb_read(4'hc, word);
        compare_count("prdata at 0xc", 32'd0, word);
        set_cfg(16'd0, 8'd0);
        check_copies();
    endtask

    task automatic test_mid_insert;
        set_cfg(16'd3, 8'd2);
        repeat (3) run_packet(8, 1'b0);
        check_copies();
    endtask

    // single-beat packets keep tlast on the last copy only
    task automatic test_seed_zero;
        set_cfg(16'd0, 8'd3);
        run_packet(3, 1'b0);
        run_packet(1, 1'b0);
        run_packet(1, 1'b0);
        run_packet(4, 1'b0);
        check_copies();
    endtask

    // short packets pass, a 7-beat packet repeats its last beat
    task automatic test_seed_beyond;
        set_cfg(16'd6, 8'd2);
        run_packet(4, 1'b0);
        run_packet(4, 1'b0);
        run_packet(7, 1'b0);
        check_copies();
    endtask

    task automatic test_backpressure;
        set_cfg(16'd3, 8'd2);
        repeat (4) run_packet(8, 1'b1);
        check_copies();
    endtask

    initial begin
        void'($urandom(32'h48a7));
        exp_copies  = 32'd0;
        cur_seed    = 0;
        cur_len     = 0;
        rst_n    = 1'b0;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = 32'd0;
        s_tdata  = '0;
        s_tkeep  = '0;
        s_tlast  = 1'b0;
        s_tvalid = 1'b0;
        m_tready = 1'b0;
        repeat (5) @(posedge clock);
        #1;
        rst_n = 1'b1;
        test_registers();
        test_mid_insert();
        test_seed_zero();
        test_seed_beyond();
        test_backpressure();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
rtl/insert_pkg.sv
rtl/insert_apb_regs.sv
rtl/axis_insert_copy.sv
rtl/axis_beat_pipe.sv
rtl/insert_top.sv
tb/insert_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it; the pass line in the output decides the status

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing -Wno-fatal -f verilog.f --top-module insert_tb -o sim_insert
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_insert)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF "All tests passed!"; then
    exit 0
fi
exit 1
